// ==== project.f ====
verilog/dcache_pkg.sv
verilog/dcache_ctrl.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_fill_buffer.sv
verilog/dcache.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f project.f \
        --top-module dcache_tb -o dcache_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/dcache_sim 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Testbench passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== verification/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam logic [31:0] seed        = 32'h48923c46;
    localparam int          num_direct  = 10;
    localparam int          num_rand    = 400;
    localparam int          max_delay   = 7;
    localparam int          max_gap     = 3;
    // worst miss is two bus waits plus four spread beats and fsm overhead
    localparam int          miss_cycles = 2 * (max_delay + 3) + 4 * (max_gap + 1) + 8;
    localparam int          cycle_limit = 16 + (num_direct + num_rand) * miss_cycles + 200;

    logic clk, rst, valid, op, addr_ok, data_ok;
    logic [31:0]  addr, wdata, rdata, rd_addr, wr_addr, ret_data, last_rd_addr, last_wr_addr;
    logic [3:0]   wstrb, wr_wstrb;
    logic [2:0]   rd_type, wr_type;
    logic         rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;
    logic [127:0] wr_data, last_wr_line;
    int           rd_count, wr_count;
    int           cycles = 0;
    logic [31:0]  rng;

    // shadow memory and shadow tags
    logic [7:0]   shadow [65536];
    logic [1:0]   sh_valid [256];
    logic [1:0]   sh_dirty [256];
    logic [19:0]  sh_tag [256][2];
    logic         sh_lru [256];        // way to evict next

    dcache dut_i (.*);

    dcache_mem_model #(.seed(seed), .max_delay(max_delay), .max_gap(max_gap)) mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "cycle limit reached");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] read_expect(input logic [31:0] a);
        logic [15:0] b;
        b = {a[15:2], 2'b00};
        return {shadow[b + 3], shadow[b + 2], shadow[b + 1], shadow[b]};    // little endian
    endfunction

    function automatic logic [127:0] line_expect(input logic [31:0] a);
        logic [127:0] line;
        for (int i = 0; i < 16; i++) begin
            line[i*8 +: 8] = shadow[{a[15:4], 4'h0} + i];
        end
        return line;
    endfunction

    // predicts hit or miss and the victim and updates shadow tags
    task automatic predict(input logic [31:0] a, input logic st, output logic is_hit,
                           output logic wb, output logic [31:0] wb_addr);
        logic [7:0] idx;
        logic       way;
        idx     = a[11:4];
        is_hit  = 1'b0;
        wb      = 1'b0;
        wb_addr = '0;
        way     = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (sh_valid[idx][w] && sh_tag[idx][w] == a[31:12]) begin
                is_hit = 1'b1;
                way    = w[0];
            end
        end
        if (!is_hit) begin
            way = !sh_valid[idx][0] ? 1'b0 : !sh_valid[idx][1] ? 1'b1 : sh_lru[idx];
            wb                 = sh_valid[idx][way] && sh_dirty[idx][way];
            wb_addr            = {sh_tag[idx][way], idx, 4'h0};
            sh_valid[idx][way] = 1'b1;
            sh_tag[idx][way]   = a[31:12];
            sh_dirty[idx][way] = st;        // store allocate leaves it dirty
        end else if (st) begin
            sh_dirty[idx][way] = 1'b1;
        end
        sh_lru[idx] = ~way;
    endtask

    task automatic check_value(input logic [127:0] got, input logic [127:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
            $display("Testbench failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // one request from start to data_ok
    //////////////////////////////////////////////////////////////////////

    task automatic do_op(input logic st, input logic [31:0] a, input logic [3:0] strb,
                         input logic [31:0] data);
        int          lat;
        int          rd_before;
        int          wr_before;
        logic        exp_hit;
        logic        exp_wb;
        logic [31:0] exp_wb_addr;
        logic [31:0] exp_word;
        lat       = 1;
        rd_before = rd_count;
        wr_before = wr_count;
        exp_word  = read_expect(a);
        predict(a, st, exp_hit, exp_wb, exp_wb_addr);
        valid = 1'b1;
        op    = st;
        addr  = a;
        wstrb = strb;
        wdata = data;
        while (!addr_ok) step();
        step();                             // acceptance edge
        valid = 1'b0;
        while (!data_ok) begin
            check_value(addr_ok, 1'b0, "addr_ok high while busy");
            step();
            lat++;
        end
        check_value(addr_ok, 1'b0, "addr_ok high with data_ok");
        if (!st) check_value(rdata, exp_word, $sformatf("load data at %h", a));
        if (exp_hit) begin
            check_value(lat, 1, "hit latency");
            check_value(rd_count - rd_before, 0, "bus read on a hit");
        end else begin
            check_value(rd_count - rd_before, 1, "line reads for a miss");
            check_value(last_rd_addr, {a[31:4], 4'h0}, "refill address");
            check_value(rd_type, dcache_pkg::bus_type_line, "read type");
        end
        check_value(wr_count - wr_before, exp_wb, "writeback count");
        if (exp_wb) begin
            check_value(last_wr_addr, exp_wb_addr, "writeback address");
            check_value(last_wr_line, line_expect(exp_wb_addr), "writeback line");
            check_value(wr_type, dcache_pkg::bus_type_line, "write type");
            check_value(wr_wstrb, 4'hf, "write strobes");
        end
        for (int b = 0; b < 4; b++) begin
            if (st && strb[b]) shadow[{a[15:2], 2'b00} + b] = data[b*8 +: 8];
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        rst   = 1'b1;
        valid = 1'b0;
        op    = 1'b0;
        addr  = '0;
        wstrb = '0;
        wdata = '0;
        rng   = seed;
        for (int s = 0; s < 256; s++) begin
            sh_valid[s] = '0;
            sh_dirty[s] = '0;
            sh_lru[s]   = 1'b0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < 65536; i++) shadow[i] = mem_i.mem[i];   // memory starts as its pattern
        check_value(addr_ok, 1'b1, "addr_ok after reset");
        check_value(data_ok, 1'b0, "data_ok after reset");
        check_value(rd_req, 1'b0, "rd_req after reset");
        check_value(wr_req, 1'b0, "wr_req after reset");

        do_op(1'b0, 32'h0000_1230, 4'h0, 32'h0);            // cold load
        do_op(1'b0, 32'h0000_1230, 4'h0, 32'h0);            // same word again is a hit
        do_op(1'b1, 32'h0000_1234, 4'b0101, 32'hdeadbeef);  // store hit
        do_op(1'b1, 32'h0000_2448, 4'b1100, 32'hcafef00d);  // store miss merged on fill
        do_op(1'b0, 32'h0000_1234, 4'h0, 32'h0);
        do_op(1'b0, 32'h0000_2448, 4'h0, 32'h0);
        // three tags in set 0x60
        do_op(1'b1, 32'h0000_3600, 4'b1111, 32'h01234567);
        do_op(1'b0, 32'h0000_4600, 4'h0, 32'h0);
        do_op(1'b0, 32'h0000_5600, 4'h0, 32'h0);            // dirty victim written back
        do_op(1'b0, 32'h0000_3604, 4'h0, 32'h0);            // clean victim needs no write

        for (int n = 0; n < num_rand; n++) begin
            rng = lcg_step(rng);
            r   = rng;
            a   = {16'h0, 2'b01, r[23:22], 6'h0, r[25:24], r[21:20], 2'b00};  // 4 tags over 4 sets
            rng = lcg_step(rng);
            do_op(r[31], a, r[19:16], rng);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/dcache_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model #(
    parameter logic [31:0] seed      = 32'h1,
    parameter int          max_delay = 7,       // longest rd_rdy / wr_rdy wait
    parameter int          max_gap   = 3        // longest idle run between beats
) (
    input  logic         clk,
    input  logic         rd_req,
    input  logic [31:0]  rd_addr,
    output logic         rd_rdy,
    output logic         ret_valid,
    output logic         ret_last,
    output logic [31:0]  ret_data,
    input  logic         wr_req,
    input  logic [31:0]  wr_addr,
    input  logic [127:0] wr_data,
    output logic         wr_rdy,
    output int           rd_count,      // accepted line reads
    output int           wr_count,      // accepted line writes
    output logic [31:0]  last_rd_addr,
    output logic [31:0]  last_wr_addr,
    output logic [127:0] last_wr_line
);

    logic [7:0]  mem [65536];           // 64 KB window, addr[15:0]
    logic [31:0] rng;
    logic [15:0] base;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;                             // drive after the edge
    endtask

    task automatic wait_random(input int limit);
        rng = lcg_step(rng);
        repeat (int'(rng[31:16]) % (limit + 1)) next_cycle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus responder, one transaction at a time
    //////////////////////////////////////////////////////////////////////

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a] = a[7:0] ^ (a[15:8] * 8'd7) ^ 8'h3c;    // pattern over all 16 bits
        end
        rng          = seed;
        rd_rdy       = 1'b0;
        wr_rdy       = 1'b0;
        ret_valid    = 1'b0;
        ret_last     = 1'b0;
        ret_data     = '0;
        rd_count     = 0;
        wr_count     = 0;
        last_rd_addr = '0;
        last_wr_addr = '0;
        last_wr_line = '0;
        forever begin
            next_cycle();
            if (wr_req) begin
                wait_random(max_delay);
                wr_rdy       = 1'b1;                        // taken at the next edge
                last_wr_addr = wr_addr;
                last_wr_line = wr_data;
                for (int i = 0; i < 16; i++) begin
                    mem[wr_addr[15:0] + 16'(i)] = wr_data[i*8 +: 8];
                end
                wr_count++;
                next_cycle();
                wr_rdy = 1'b0;
            end else if (rd_req) begin
                wait_random(max_delay);
                rd_rdy       = 1'b1;
                last_rd_addr = rd_addr;
                rd_count++;
                next_cycle();
                rd_rdy = 1'b0;
                for (int w = 0; w < 4; w++) begin
                    wait_random(max_gap);                   // gaps between beats
                    base      = rd_addr[15:0] + 16'(w * 4);
                    ret_valid = 1'b1;
                    ret_last  = (w == 3);
                    ret_data  = {mem[base + 16'd3], mem[base + 16'd2],
                                 mem[base + 16'd1], mem[base]};
                    next_cycle();
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  logic         clk,
    input  logic         rst,
    // cpu side
    input  logic         valid,
    input  logic         op,            // 1 = store
    input  logic [31:0]  addr,
    input  logic [3:0]   wstrb,
    input  logic [31:0]  wdata,
    output logic         addr_ok,
    output logic         data_ok,
    output logic [31:0]  rdata,
    // memory side
    output logic         rd_req,
    output logic [2:0]   rd_type,
    output logic [31:0]  rd_addr,
    input  logic         rd_rdy,
    input  logic         ret_valid,
    input  logic         ret_last,
    input  logic [31:0]  ret_data,
    output logic         wr_req,
    output logic [2:0]   wr_type,
    output logic [31:0]  wr_addr,
    output logic [3:0]   wr_wstrb,
    output logic [127:0] wr_data,
    input  logic         wr_rdy
);

    dcache_pkg::cache_addr_t req_addr_q;
    logic        req_op_q;
    logic [3:0]  req_wstrb_q;
    logic [31:0] req_wdata_q;
    logic [1:0]  req_word;

    logic capture, hit, hit_way, victim_way, victim_valid, victim_dirty;
    logic store_hit_write, line_write, tag_write, lru_touch, fill_clear;
    logic rdata_from_fill, way_sel, line_ready;
    logic [dcache_pkg::tag_bits-1:0]      victim_tag;
    logic [31:0]                          read_word;
    logic [32*dcache_pkg::line_words-1:0] victim_line, fill_line;

    //////////////////////////////////////////////////////////////////////
    // request register, loaded on acceptance
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            req_addr_q.word <= '0;
            req_op_q        <= 1'b0;
        end else if (capture) begin
            req_addr_q.word <= addr;
            req_op_q        <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            req_wstrb_q <= wstrb;
            req_wdata_q <= wdata;
        end
    end

    assign req_word = req_addr_q.fields.offset[dcache_pkg::offset_bits-1:2];
    assign rdata    = rdata_from_fill ? fill_line[req_word*32 +: 32] : read_word;

    // bus fields, line aligned
    assign rd_type  = dcache_pkg::bus_type_line;
    assign rd_addr  = {req_addr_q.fields.tag, req_addr_q.fields.index,
                       {dcache_pkg::offset_bits{1'b0}}};
    assign wr_type  = dcache_pkg::bus_type_line;
    assign wr_addr  = {victim_tag, req_addr_q.fields.index, {dcache_pkg::offset_bits{1'b0}}};
    assign wr_wstrb = 4'hf;
    assign wr_data  = victim_line;

    dcache_ctrl ctrl_i (
        .clk, .rst, .valid, .req_op(req_op_q), .hit, .hit_way, .victim_way,
        .victim_valid, .victim_dirty, .wr_rdy, .rd_rdy, .line_ready,
        .addr_ok, .data_ok, .capture, .rd_req, .wr_req, .store_hit_write,
        .line_write, .tag_write, .lru_touch, .fill_clear, .rdata_from_fill, .way_sel
    );

    dcache_tag_array tag_i (
        .clk, .rst, .req_addr(req_addr_q), .store(req_op_q), .tag_write, .lru_touch,
        .fill_way(way_sel), .hit, .hit_way, .victim_way, .victim_valid, .victim_dirty,
        .victim_tag
    );

    dcache_data_array data_i (
        .clk, .req_index(req_addr_q.fields.index), .req_word, .way_sel, .store_hit_write,
        .wstrb(req_wstrb_q), .wdata(req_wdata_q), .line_write, .fill_line,
        .read_word, .victim_line
    );

    dcache_fill_buffer fill_i (
        .clk, .rst, .fill_clear, .ret_valid, .ret_last, .ret_data,
        .merge_store(req_op_q), .req_word, .wstrb(req_wstrb_q), .wdata(req_wdata_q),
        .line_ready, .fill_line
    );

endmodule

`default_nettype wire

// ==== verilog/dcache_fill_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_fill_buffer (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         fill_clear,
    input  logic                                         ret_valid,
    input  logic                                         ret_last,
    input  logic [31:0]                                  ret_data,
    input  logic                                         merge_store,   // miss was a store
    input  logic [$clog2(dcache_pkg::line_words)-1:0]    req_word,
    input  logic [3:0]                                   wstrb,
    input  logic [31:0]                                  wdata,
    output logic                                         line_ready,
    output logic [32*dcache_pkg::line_words-1:0]         fill_line
);

    logic [$clog2(dcache_pkg::line_words)-1:0] beat_q;
    logic [31:0]                               word_q [dcache_pkg::line_words];

    // beat counter, words arrive in order
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_q <= '0;
        end else if (fill_clear) begin
            beat_q <= '0;
        end else if (ret_valid) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ret_valid) begin
            word_q[beat_q] <= ret_data;
        end
    end

    // high the cycle after the last beat lands
    always_ff @(posedge clk) begin
        if (rst) begin
            line_ready <= 1'b0;
        end else begin
            line_ready <= ret_valid && ret_last;
        end
    end

    // overlay pending store bytes on the addressed word
    always_comb begin
        for (int w = 0; w < dcache_pkg::line_words; w++) begin
            for (int b = 0; b < 4; b++) begin
                if (merge_store && req_word == w && wstrb[b]) begin
                    fill_line[w*32 + b*8 +: 8] = wdata[b*8 +: 8];
                end else begin
                    fill_line[w*32 + b*8 +: 8] = word_q[w][b*8 +: 8];
                end
            end
        end
    end

    // memory ends every line on exactly the fourth beat
    assert property (@(posedge clk) disable iff (rst)
        ret_valid |-> (ret_last == (beat_q == dcache_pkg::line_words - 1)));

endmodule

`default_nettype wire

// ==== verilog/dcache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array (
    input  logic                                         clk,
    input  logic [dcache_pkg::index_bits-1:0]            req_index,
    input  logic [$clog2(dcache_pkg::line_words)-1:0]    req_word,
    input  logic                                         way_sel,
    input  logic                                         store_hit_write,
    input  logic [3:0]                                   wstrb,
    input  logic [31:0]                                  wdata,
    input  logic                                         line_write,
    input  logic [32*dcache_pkg::line_words-1:0]         fill_line,
    output logic [31:0]                                  read_word,
    output logic [32*dcache_pkg::line_words-1:0]         victim_line
);

    localparam int sets = 1 << dcache_pkg::index_bits;

    logic [32*dcache_pkg::line_words-1:0] line_mem [dcache_pkg::num_ways][sets];
    logic [32*dcache_pkg::line_words-1:0] cur_line;

    //////////////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////////////

    assign cur_line    = line_mem[way_sel][req_index];
    assign read_word   = cur_line[req_word*32 +: 32];   // word select
    assign victim_line = cur_line;                      // whole line for writeback

    //////////////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (line_write) begin
            line_mem[way_sel][req_index] <= fill_line;  // refill, store already merged
        end else if (store_hit_write) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    line_mem[way_sel][req_index][req_word*32 + b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array (
    input  logic                                 clk,
    input  logic                                 rst,
    input  dcache_pkg::cache_addr_t              req_addr,
    input  logic                                 store,     // request is a store
    input  logic                                 tag_write, // install new line
    input  logic                                 lru_touch,
    input  logic                                 fill_way,  // way being written or touched
    output logic                                 hit,
    output logic                                 hit_way,
    output logic                                 victim_way,
    output logic                                 victim_valid,
    output logic                                 victim_dirty,
    output logic [dcache_pkg::tag_bits-1:0]      victim_tag
);

    localparam int sets = 1 << dcache_pkg::index_bits;

    logic [dcache_pkg::num_ways-1:0] valid_q [sets];
    logic [dcache_pkg::num_ways-1:0] dirty_q [sets];
    logic [sets-1:0]                 lru_q;             // index of lru way
    logic [dcache_pkg::tag_bits-1:0] tag_mem [dcache_pkg::num_ways][sets];

    logic [dcache_pkg::index_bits-1:0] idx;
    logic [dcache_pkg::num_ways-1:0]   way_hit;

    assign idx = req_addr.fields.index;

    //////////////////////////////////////////////////////////////////////
    // compare and victim choice
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            way_hit[w] = valid_q[idx][w] && (tag_mem[w][idx] == req_addr.fields.tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // empty way wins, else lru
    assign victim_way = !valid_q[idx][0] ? 1'b0 :
                        !valid_q[idx][1] ? 1'b1 : lru_q[idx];

    assign victim_valid = valid_q[idx][victim_way];
    assign victim_dirty = dirty_q[idx][victim_way];
    assign victim_tag   = tag_mem[victim_way][idx];

    //////////////////////////////////////////////////////////////////////
    // state update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (tag_write) begin
                valid_q[idx][fill_way] <= 1'b1;
                dirty_q[idx][fill_way] <= store;    // store allocate is dirty
            end else if (lru_touch && store) begin
                dirty_q[idx][fill_way] <= 1'b1;     // store hit
            end
            if (lru_touch) begin
                lru_q[idx] <= ~fill_way;            // other way now oldest
            end
        end
    end

    // tags are plain storage
    always_ff @(posedge clk) begin
        if (tag_write) begin
            tag_mem[fill_way][idx] <= req_addr.fields.tag;
        end
    end

    // one tag never lives in both ways of a set
    assert property (@(posedge clk) disable iff (rst) !(&way_hit));

endmodule

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic valid,             // cpu request
    input  logic req_op,            // registered op where 1 means store
    input  logic hit,
    input  logic hit_way,
    input  logic victim_way,
    input  logic victim_valid,
    input  logic victim_dirty,
    input  logic wr_rdy,
    input  logic rd_rdy,
    input  logic line_ready,        // merged line from fill buffer
    output logic addr_ok,
    output logic data_ok,
    output logic capture,           // load request register
    output logic rd_req,
    output logic wr_req,
    output logic store_hit_write,
    output logic line_write,
    output logic tag_write,
    output logic lru_touch,
    output logic fill_clear,
    output logic rdata_from_fill,
    output logic way_sel            // way seen by both arrays
);

    // state encoding
    localparam logic [2:0] st_idle      = 3'd0;
    localparam logic [2:0] st_lookup    = 3'd1;
    localparam logic [2:0] st_writeback = 3'd2;
    localparam logic [2:0] st_fetch     = 3'd3;
    localparam logic [2:0] st_refill    = 3'd4;
    localparam logic [2:0] st_respond   = 3'd5;

    logic [2:0] state;
    logic [2:0] state_nx;
    logic       fill_way_q;         // victim held for the whole miss

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            fill_way_q <= 1'b0;
        end else begin
            state <= state_nx;
            if (state == st_lookup && !hit) begin
                fill_way_q <= victim_way;   // lock before lru moves
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nx = state;
        case (state)
            st_idle: begin
                if (valid) begin
                    state_nx = st_lookup;
                end
            end
            st_lookup: begin
                if (hit) begin
                    state_nx = st_idle;
                end else if (victim_valid && victim_dirty) begin
                    state_nx = st_writeback;    // dirty victim goes out first
                end else begin
                    state_nx = st_fetch;
                end
            end
            st_writeback: begin
                if (wr_rdy) begin
                    state_nx = st_fetch;
                end
            end
            st_fetch: begin
                if (rd_rdy) begin
                    state_nx = st_refill;
                end
            end
            st_refill: begin
                if (line_ready) begin
                    state_nx = st_respond;
                end
            end
            default: state_nx = st_idle;        // respond and unused codes
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // outputs all decoded from state
    //////////////////////////////////////////////////////////////////////

    assign addr_ok         = state == st_idle;
    assign capture         = addr_ok && valid;
    assign data_ok         = (state == st_lookup && hit) || state == st_respond;
    assign store_hit_write = state == st_lookup && hit && req_op;
    assign fill_clear      = state == st_lookup && !hit;   // restart beat count
    assign wr_req          = state == st_writeback;        // held until wr_rdy
    assign rd_req          = state == st_fetch;            // held until rd_rdy
    assign line_write      = state == st_refill && line_ready;
    assign tag_write       = line_write;                   // install with the data
    assign lru_touch       = (state == st_lookup && hit) || line_write;
    assign rdata_from_fill = state == st_respond;
    assign way_sel         = (state == st_lookup) ? hit_way : fill_way_q;

    // never both bus requests at once
    assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req));

    // merged line only lands while a refill waits for it
    assert property (@(posedge clk) disable iff (rst)
        line_ready |-> state == st_refill);

    // read request held until the bus takes it
    assert property (@(posedge clk) disable iff (rst)
        (rd_req && !rd_rdy) |=> rd_req);

endmodule

`default_nettype wire

// ==== verilog/dcache_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////////////////////////
// dcache geometry: 2 ways x 256 sets x 16-byte lines
//////////////////////////////////////////////////////////////////////

package dcache_pkg;

    // address layout: [31:12] tag, [11:4] index, [3:0] offset
    localparam int tag_bits    = 20;
    localparam int index_bits  = 8;     // 256 sets
    localparam int offset_bits = 4;     // byte within line
    localparam int line_words  = 4;     // 32-bit words per line
    localparam int num_ways    = 2;

    // bus request type, whole cache line
    localparam logic [2:0] bus_type_line = 3'b100;

    // one address word, seen raw or split into lookup fields
    typedef union packed {
        logic [31:0] word;              // bus address, raw
        struct packed {
            logic [tag_bits-1:0]    tag;
            logic [index_bits-1:0]  index;
            logic [offset_bits-1:0] offset;
        } fields;
    } cache_addr_t;

endpackage

`default_nettype wire
